//--- common/xlate_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types and constants for the address translation unit
// Page offset of 4 KiB passes through translation unchanged
// Config address is {entry index, field selector}
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package xlate_pkg;

  // Address widths
  localparam int unsigned InAddrBits  = 32;
  localparam int unsigned OutAddrBits = 36;
  localparam int unsigned PageBits    = 12;

  typedef logic [InAddrBits-1:0]           in_addr_t;
  typedef logic [OutAddrBits-1:0]          out_addr_t;
  typedef logic [InAddrBits-PageBits-1:0]  in_page_t;
  typedef logic [OutAddrBits-PageBits-1:0] out_page_t;

  // Transaction ID and response code
  typedef logic [3:0] id_t;
  typedef logic [1:0] resp_t;

  localparam resp_t RespOkay   = 2'b00;
  localparam resp_t RespSlvErr = 2'b10;

  // One range of the first-level table
  typedef struct packed {
    in_page_t  first_page;
    in_page_t  last_page;
    out_page_t base_page;
    logic      valid;
  } tlb_entry_t;

  // Registered lookup result
  typedef struct packed {
    logic      hit;
    out_addr_t addr;
  } xlate_res_t;

  // Configuration port
  localparam int unsigned CfgFieldBits = 2;
  typedef logic [31:0] cfg_data_t;

  // Field selectors, low bits of the config address
  localparam logic [CfgFieldBits-1:0] CfgSelFirst = 2'd0;
  localparam logic [CfgFieldBits-1:0] CfgSelLast  = 2'd1;
  localparam logic [CfgFieldBits-1:0] CfgSelBase  = 2'd2;
  localparam logic [CfgFieldBits-1:0] CfgSelValid = 2'd3;

endpackage

//--- common/tlb_lookup_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lookup channel between front end and table
// Request and result each use valid/ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface tlb_lookup_if;
  import xlate_pkg::*;

  // Request channel
  logic       req_valid;
  logic       req_ready;
  in_addr_t   req_addr;

  // Result channel
  logic       res_valid;
  logic       res_ready;
  xlate_res_t res;

  // Front end side
  modport requester (
    output req_valid, req_addr, res_ready,
    input  req_ready, res_valid, res
  );

  // Table side
  modport responder (
    input  req_valid, req_addr, res_ready,
    output req_ready, res_valid, res
  );

endinterface

//--- tlb/tlb_l1.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// First-level range table, registered lookup
// NumEntries must be at least 2
// Config writes only while no lookup is in flight
// One result held at a time, half throughput
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tlb_l1 #(
  parameter int unsigned NumEntries = 4
) (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  input  logic                                                cfg_we_i,
  input  logic [$clog2(NumEntries)+xlate_pkg::CfgFieldBits-1:0] cfg_addr_i,
  input  xlate_pkg::cfg_data_t                                cfg_wdata_i,
  tlb_lookup_if.responder                                     lookup
);
  import xlate_pkg::*;

  localparam int unsigned IdxBits = $clog2(NumEntries);

  tlb_entry_t              entries_q [NumEntries];
  logic [IdxBits-1:0]      cfg_idx;
  logic [CfgFieldBits-1:0] cfg_sel;

  in_page_t                req_page;
  logic [NumEntries-1:0]   entry_hit;
  xlate_res_t              res_d;
  xlate_res_t              res_q;
  logic                    res_valid_d;
  logic                    res_valid_q;
  logic                    req_ready_q;
  logic                    req_fire;

  // Config address split
  assign cfg_idx = cfg_addr_i[IdxBits+CfgFieldBits-1:CfgFieldBits];
  assign cfg_sel = cfg_addr_i[CfgFieldBits-1:0];

  // Field-by-field config writes, all entries invalid after reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NumEntries; i++) begin
        entries_q[i] <= '0;
      end
    end else if (cfg_we_i && (int'(cfg_idx) < NumEntries)) begin
      case (cfg_sel)
        CfgSelFirst: entries_q[cfg_idx].first_page <= cfg_wdata_i[$bits(in_page_t)-1:0];
        CfgSelLast:  entries_q[cfg_idx].last_page  <= cfg_wdata_i[$bits(in_page_t)-1:0];
        CfgSelBase:  entries_q[cfg_idx].base_page  <= cfg_wdata_i[$bits(out_page_t)-1:0];
        default:     entries_q[cfg_idx].valid      <= cfg_wdata_i[0];
      endcase
    end
  end

  // Page number of the incoming address
  assign req_page = lookup.req_addr[$bits(in_addr_t)-1:PageBits];

  // Range compare per entry
  always_comb begin
    for (int i = 0; i < NumEntries; i++) begin
      entry_hit[i] = entries_q[i].valid &&
                     (req_page >= entries_q[i].first_page) &&
                     (req_page <= entries_q[i].last_page);
    end
  end

  // Priority select, walk down so the lowest index is applied last
  always_comb begin
    out_page_t xpage;
    res_d = '0;
    xpage = '0;
    for (int i = NumEntries - 1; i >= 0; i--) begin
      if (entry_hit[i]) begin
        // Offset into the range added to the output base
        xpage = entries_q[i].base_page +
                out_page_t'(req_page - entries_q[i].first_page);
        res_d.hit  = 1'b1;
        res_d.addr = {xpage, lookup.req_addr[PageBits-1:0]};
      end
    end
  end

  assign req_fire = lookup.req_valid && lookup.req_ready;

  // Result slot occupancy
  always_comb begin
    res_valid_d = res_valid_q;
    if (res_valid_q && lookup.res_ready) begin
      res_valid_d = 1'b0;
    end
    if (req_fire) begin
      res_valid_d = 1'b1;
    end
  end

  // Ready is registered, so it comes up one cycle after reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      res_valid_q <= 1'b0;
      req_ready_q <= 1'b0;
    end else begin
      res_valid_q <= res_valid_d;
      req_ready_q <= !res_valid_d;
    end
  end

  // Captured once per accepted lookup
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      res_q <= res_d;
    end
  end

  assign lookup.req_ready = req_ready_q;
  assign lookup.res_valid = res_valid_q;
  assign lookup.res       = res_q;

  // Table never takes a new lookup while an old result waits
  a_no_req_while_held: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    lookup.res_valid |-> !(lookup.req_valid && lookup.req_ready)
  );

endmodule

//--- src/xlate_front.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fork, join and steer stage of the translator
// CutReq adds one cycle and one request of storage
// Upstream address must stay stable until accepted
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module xlate_front #(
  parameter bit CutReq = 1'b1
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  slv_req_valid_i,
  output logic                  slv_req_ready_o,
  input  xlate_pkg::in_addr_t   slv_req_addr_i,
  input  xlate_pkg::id_t        slv_req_id_i,
  input  logic                  slv_req_write_i,
  tlb_lookup_if.requester       lookup,
  output logic                  mst_req_valid_o,
  input  logic                  mst_req_ready_i,
  output xlate_pkg::out_addr_t  mst_req_addr_o,
  output xlate_pkg::id_t        mst_req_id_o,
  output logic                  mst_req_write_o,
  output logic                  miss_valid_o,
  input  logic                  miss_ready_i,
  output xlate_pkg::id_t        miss_id_o
);
  import xlate_pkg::*;

  // ID and write flag ride next to the lookup
  logic      side_valid_q;
  id_t       side_id_q;
  logic      side_write_q;
  logic      side_ready;
  logic      req_fire;

  logic      join_valid;
  logic      join_ready;
  logic      join_fire;

  // Stage that feeds the steering
  logic      out_valid;
  logic      out_ready;
  logic      out_hit;
  out_addr_t out_addr;
  id_t       out_id;
  logic      out_write;

  // Fork: table and side register must both take the request
  assign side_ready       = !side_valid_q || join_fire;
  assign lookup.req_valid = slv_req_valid_i && side_ready;
  assign lookup.req_addr  = slv_req_addr_i;
  assign slv_req_ready_o  = lookup.req_ready && side_ready;
  assign req_fire         = slv_req_valid_i && slv_req_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      side_valid_q <= 1'b0;
    end else if (req_fire) begin
      side_valid_q <= 1'b1;
    end else if (join_fire) begin
      side_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      side_id_q    <= slv_req_id_i;
      side_write_q <= slv_req_write_i;
    end
  end

  // Join side register with the table result
  assign join_valid       = side_valid_q && lookup.res_valid;
  assign join_fire        = join_valid && join_ready;
  assign lookup.res_ready = side_valid_q && join_ready;

  if (CutReq) begin : gen_cut
    logic      buf_valid_q;
    logic      buf_hit_q;
    out_addr_t buf_addr_q;
    id_t       buf_id_q;
    logic      buf_write_q;

    // One-entry buffer, refills in the cycle it drains
    assign join_ready = !buf_valid_q || out_ready;

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        buf_valid_q <= 1'b0;
      end else if (join_ready) begin
        buf_valid_q <= join_valid;
      end
    end

    always_ff @(posedge clk_i) begin
      if (join_fire) begin
        buf_hit_q   <= lookup.res.hit;
        buf_addr_q  <= lookup.res.addr;
        buf_id_q    <= side_id_q;
        buf_write_q <= side_write_q;
      end
    end

    assign out_valid = buf_valid_q;
    assign out_hit   = buf_hit_q;
    assign out_addr  = buf_addr_q;
    assign out_id    = buf_id_q;
    assign out_write = buf_write_q;
  end else begin : gen_no_cut
    // Joined request goes straight to the steering
    assign join_ready = out_ready;
    assign out_valid  = join_valid;
    assign out_hit    = lookup.res.hit;
    assign out_addr   = lookup.res.addr;
    assign out_id     = side_id_q;
    assign out_write  = side_write_q;
  end

  // Hits downstream, misses to the error responder
  assign out_ready       = out_hit ? mst_req_ready_i : miss_ready_i;
  assign mst_req_valid_o = out_valid && out_hit;
  assign mst_req_addr_o  = out_addr;
  assign mst_req_id_o    = out_id;
  assign mst_req_write_o = out_write;
  assign miss_valid_o    = out_valid && !out_hit;
  assign miss_id_o       = out_id;

  // Stalled downstream request keeps its payload
  a_mst_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    mst_req_valid_o && !mst_req_ready_i |=>
      mst_req_valid_o && $stable(mst_req_addr_o) &&
      $stable(mst_req_id_o) && $stable(mst_req_write_o)
  );

endmodule

//--- src/err_responder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Error responder for missed requests
// One miss at a time, answered with SLVERR
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module err_responder (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             miss_valid_i,
  output logic             miss_ready_o,
  input  xlate_pkg::id_t   miss_id_i,
  output logic             err_valid_o,
  input  logic             err_ready_i,
  output xlate_pkg::id_t   err_id_o,
  output xlate_pkg::resp_t err_resp_o
);
  import xlate_pkg::*;

  logic err_valid_q;
  id_t  err_id_q;

  // Empty slot takes a miss
  assign miss_ready_o = !err_valid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      err_valid_q <= 1'b0;
    end else if (miss_valid_i && miss_ready_o) begin
      err_valid_q <= 1'b1;
    end else if (err_ready_i) begin
      // Response taken, slot free next cycle
      err_valid_q <= 1'b0;
    end
  end

  // Keep the ID of the absorbed request
  always_ff @(posedge clk_i) begin
    if (miss_valid_i && miss_ready_o) begin
      err_id_q <= miss_id_i;
    end
  end

  assign err_valid_o = err_valid_q;
  assign err_id_o    = err_id_q;
  assign err_resp_o  = RespSlvErr;

endmodule

//--- src/rsp_merge.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin merge of two response streams
// Combinational path, grant held while stalled
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module rsp_merge (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             mst_rsp_valid_i,
  output logic             mst_rsp_ready_o,
  input  xlate_pkg::id_t   mst_rsp_id_i,
  input  xlate_pkg::resp_t mst_rsp_resp_i,
  input  logic             err_valid_i,
  output logic             err_ready_o,
  input  xlate_pkg::id_t   err_id_i,
  input  xlate_pkg::resp_t err_resp_i,
  output logic             slv_rsp_valid_o,
  input  logic             slv_rsp_ready_i,
  output xlate_pkg::id_t   slv_rsp_id_o,
  output xlate_pkg::resp_t slv_rsp_resp_o
);

  // Select 0 is the downstream source, 1 the error source
  logic last_q;
  logic lock_q;
  logic lock_sel_q;
  logic both;
  logic sel;

  assign both = mst_rsp_valid_i && err_valid_i;

  // Locked grant first, then round robin, then whoever is valid
  always_comb begin
    if (lock_q) begin
      sel = lock_sel_q;
    end else if (both) begin
      sel = !last_q;
    end else begin
      sel = err_valid_i;
    end
  end

  assign slv_rsp_valid_o = sel ? err_valid_i : mst_rsp_valid_i;
  assign slv_rsp_id_o    = sel ? err_id_i    : mst_rsp_id_i;
  assign slv_rsp_resp_o  = sel ? err_resp_i  : mst_rsp_resp_i;
  assign mst_rsp_ready_o = !sel && slv_rsp_ready_i;
  assign err_ready_o     = sel && slv_rsp_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      last_q     <= 1'b0;
      lock_q     <= 1'b0;
      lock_sel_q <= 1'b0;
    end else begin
      lock_q <= slv_rsp_valid_o && !slv_rsp_ready_i;
      if (slv_rsp_valid_o && !slv_rsp_ready_i) begin
        lock_sel_q <= sel;
      end
      // Flip only after a contested transfer
      if (slv_rsp_valid_o && slv_rsp_ready_i && both) begin
        last_q <= sel;
      end
    end
  end

  // Stalled response keeps its source and payload
  a_rsp_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    slv_rsp_valid_o && !slv_rsp_ready_i |=>
      slv_rsp_valid_o && $stable(slv_rsp_id_o) && $stable(slv_rsp_resp_o)
  );

endmodule

//--- src/xlate_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address translation unit, top level
// One response per request, order not kept
// Configure only while no request is in flight
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module xlate_top #(
  parameter int unsigned NumEntries = 4,
  parameter bit          CutReq     = 1'b1
) (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  input  logic                                                cfg_we_i,
  input  logic [$clog2(NumEntries)+xlate_pkg::CfgFieldBits-1:0] cfg_addr_i,
  input  xlate_pkg::cfg_data_t                                cfg_wdata_i,
  input  logic                                                slv_req_valid_i,
  output logic                                                slv_req_ready_o,
  input  xlate_pkg::in_addr_t                                 slv_req_addr_i,
  input  xlate_pkg::id_t                                      slv_req_id_i,
  input  logic                                                slv_req_write_i,
  output logic                                                mst_req_valid_o,
  input  logic                                                mst_req_ready_i,
  output xlate_pkg::out_addr_t                                mst_req_addr_o,
  output xlate_pkg::id_t                                      mst_req_id_o,
  output logic                                                mst_req_write_o,
  input  logic                                                mst_rsp_valid_i,
  output logic                                                mst_rsp_ready_o,
  input  xlate_pkg::id_t                                      mst_rsp_id_i,
  input  xlate_pkg::resp_t                                    mst_rsp_resp_i,
  output logic                                                slv_rsp_valid_o,
  input  logic                                                slv_rsp_ready_i,
  output xlate_pkg::id_t                                      slv_rsp_id_o,
  output xlate_pkg::resp_t                                    slv_rsp_resp_o
);
  import xlate_pkg::*;

  // Miss path wires
  logic  miss_valid;
  logic  miss_ready;
  id_t   miss_id;
  logic  err_valid;
  logic  err_ready;
  id_t   err_id;
  resp_t err_resp;

  tlb_lookup_if lookup_if ();

  tlb_l1 #(
    .NumEntries ( NumEntries )
  ) tlb_l1_i (
    .clk_i,
    .rst_n_i,
    .cfg_we_i,
    .cfg_addr_i,
    .cfg_wdata_i,
    .lookup     ( lookup_if.responder )
  );

  xlate_front #(
    .CutReq ( CutReq )
  ) xlate_front_i (
    .clk_i,
    .rst_n_i,
    .slv_req_valid_i,
    .slv_req_ready_o,
    .slv_req_addr_i,
    .slv_req_id_i,
    .slv_req_write_i,
    .lookup          ( lookup_if.requester ),
    .mst_req_valid_o,
    .mst_req_ready_i,
    .mst_req_addr_o,
    .mst_req_id_o,
    .mst_req_write_o,
    .miss_valid_o    ( miss_valid ),
    .miss_ready_i    ( miss_ready ),
    .miss_id_o       ( miss_id    )
  );

  err_responder err_responder_i (
    .clk_i,
    .rst_n_i,
    .miss_valid_i ( miss_valid ),
    .miss_ready_o ( miss_ready ),
    .miss_id_i    ( miss_id    ),
    .err_valid_o  ( err_valid  ),
    .err_ready_i  ( err_ready  ),
    .err_id_o     ( err_id     ),
    .err_resp_o   ( err_resp   )
  );

  rsp_merge rsp_merge_i (
    .clk_i,
    .rst_n_i,
    .mst_rsp_valid_i,
    .mst_rsp_ready_o,
    .mst_rsp_id_i,
    .mst_rsp_resp_i,
    .err_valid_i     ( err_valid ),
    .err_ready_o     ( err_ready ),
    .err_id_i        ( err_id    ),
    .err_resp_i      ( err_resp  ),
    .slv_rsp_valid_o,
    .slv_rsp_ready_i,
    .slv_rsp_id_o,
    .slv_rsp_resp_o
  );

endmodule

//--- test/tb_xlate_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Random testbench for the address translation unit
// Fixed seed, DUT built with 4 entries and CutReq set
// Config is only written while nothing is in flight
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_xlate_top;
  import xlate_pkg::*;

  localparam int unsigned NumEntries   = 4;
  localparam int unsigned CfgAddrBits  = $clog2(NumEntries) + CfgFieldBits;
  localparam int unsigned ReqsPerPhase = 60;
  localparam int unsigned TotalReqs    = ReqsPerPhase * 5;
  localparam int unsigned ClkPeriod    = 40;

  logic                   clk;
  logic                   rst_n;
  logic                   cfg_we;
  logic [CfgAddrBits-1:0] cfg_addr;
  cfg_data_t              cfg_wdata;
  logic                   slv_req_valid;
  logic                   slv_req_ready_o;
  in_addr_t               slv_req_addr;
  id_t                    slv_req_id;
  logic                   slv_req_write;
  logic                   mst_req_valid_o;
  logic                   mst_req_ready;
  out_addr_t              mst_req_addr_o;
  id_t                    mst_req_id_o;
  logic                   mst_req_write_o;
  logic                   mst_rsp_valid;
  logic                   mst_rsp_ready_o;
  id_t                    mst_rsp_id;
  logic                   slv_rsp_valid_o;
  logic                   slv_rsp_ready;
  id_t                    slv_rsp_id_o;
  resp_t                  slv_rsp_resp_o;

  // Model of the table, mirrors every config write
  in_page_t  m_first [NumEntries];
  in_page_t  m_last  [NumEntries];
  out_page_t m_base  [NumEntries];
  logic      m_valid [NumEntries];

  // Expected downstream requests as {addr, id, write}, in order
  logic [40:0] exp_q [$];
  // Per-ID scoreboard
  logic [15:0] pending;
  resp_t       exp_resp [16];
  // IDs waiting for a downstream response
  id_t         dn_q [$];
  logic        dn_taken;
  int unsigned dn_wait;

  int   seed = 32'h18848f40;
  logic rand_ready;
  int   n_req;
  int   n_rsp;
  int   n_checks;
  int   n_errors;

  xlate_top #(
    .NumEntries ( NumEntries ),
    .CutReq     ( 1'b1       )
  ) xlate_top_i (
    .clk_i           ( clk             ),
    .rst_n_i         ( rst_n           ),
    .cfg_we_i        ( cfg_we          ),
    .cfg_addr_i      ( cfg_addr        ),
    .cfg_wdata_i     ( cfg_wdata       ),
    .slv_req_valid_i ( slv_req_valid   ),
    .slv_req_ready_o ( slv_req_ready_o ),
    .slv_req_addr_i  ( slv_req_addr    ),
    .slv_req_id_i    ( slv_req_id      ),
    .slv_req_write_i ( slv_req_write   ),
    .mst_req_valid_o ( mst_req_valid_o ),
    .mst_req_ready_i ( mst_req_ready   ),
    .mst_req_addr_o  ( mst_req_addr_o  ),
    .mst_req_id_o    ( mst_req_id_o    ),
    .mst_req_write_o ( mst_req_write_o ),
    .mst_rsp_valid_i ( mst_rsp_valid   ),
    .mst_rsp_ready_o ( mst_rsp_ready_o ),
    .mst_rsp_id_i    ( mst_rsp_id      ),
    .mst_rsp_resp_i  ( RespOkay        ),
    .slv_rsp_valid_o ( slv_rsp_valid_o ),
    .slv_rsp_ready_i ( slv_rsp_ready   ),
    .slv_rsp_id_o    ( slv_rsp_id_o    ),
    .slv_rsp_resp_o  ( slv_rsp_resp_o  )
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Ends a run that stops making progress
  initial begin
    #(TotalReqs * 40 * ClkPeriod);
    $display("Timeout: run hung with %0d of %0d requests answered", n_rsp, n_req);
    $display("SOME TESTS FAILED");
    $finish;
  end

  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("** Error at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // Translation rule: first valid range holding the page, offset kept
  function automatic logic [36:0] model_xlate(input in_addr_t addr);
    in_page_t  page;
    out_page_t xpage;
    logic      found;
    page  = addr[31:PageBits];
    found = 1'b0;
    xpage = '0;
    for (int e = 0; e < NumEntries; e++) begin
      if (!found && m_valid[e] && page >= m_first[e] && page <= m_last[e]) begin
        found = 1'b1;
        xpage = m_base[e] + {4'b0, page - m_first[e]};
      end
    end
    return {found, xpage, addr[PageBits-1:0]};
  endfunction

  // Entered and left on a falling edge
  task automatic cfg_write(input int unsigned e, input logic [1:0] sel,
                           input cfg_data_t data);
    cfg_we    = 1'b1;
    cfg_addr  = CfgAddrBits'((e << CfgFieldBits) | sel);
    cfg_wdata = data;
    @(negedge clk);
    cfg_we = 1'b0;
    case (sel)
      2'd0:    m_first[e] = data[19:0];
      2'd1:    m_last[e]  = data[19:0];
      2'd2:    m_base[e]  = data[23:0];
      default: m_valid[e] = data[0];
    endcase
  endtask

  task automatic config_ranges(input logic overlap);
    in_page_t first;
    in_page_t last;
    for (int e = 0; e < NumEntries; e++) begin
      if (overlap) begin
        // All ranges share pages around 0x100
        first = 20'h100 + 20'($random(seed) & 'h3f);
        last  = first + 20'h40 + 20'($random(seed) & 'h3f);
      end else begin
        first = 20'(e << 8) | 20'($random(seed) & 'h3f);
        last  = first + 20'($random(seed) & 'h7f);
      end
      cfg_write(e, 2'd0, first);
      cfg_write(e, 2'd1, last);
      cfg_write(e, 2'd2, $random(seed));
      cfg_write(e, 2'd3, 32'd1);
    end
  endtask

  // Mostly inside entry e, sometimes one page past it or anywhere
  function automatic in_addr_t addr_near(input int unsigned e);
    in_page_t page;
    in_page_t span;
    span = m_last[e] - m_first[e] + 20'd2;
    page = m_first[e] + 20'($unsigned($random(seed)) % span);
    if (($random(seed) & 7) == 0) begin
      page = 20'($random(seed));
    end
    return {page, 12'($random(seed))};
  endfunction

  // Issues one request with a free ID and records what it should produce
  task automatic send_req(input in_addr_t addr, input logic wr);
    id_t         id;
    logic [36:0] res;
    int          tries;
    id    = 4'($random(seed));
    tries = 0;
    while (pending[id]) begin
      id = id + 4'd1;
      tries++;
      if (tries == 16) begin
        @(negedge clk);
        tries = 0;
      end
    end
    slv_req_valid = 1'b1;
    slv_req_addr  = addr;
    slv_req_id    = id;
    slv_req_write = wr;
    do @(posedge clk); while (!slv_req_ready_o);
    res          = model_xlate(addr);
    pending[id]  = 1'b1;
    exp_resp[id] = res[36] ? RespOkay : RespSlvErr;
    if (res[36]) begin
      exp_q.push_back({res[35:0], id, wr});
    end
    n_req++;
    @(negedge clk);
    slv_req_valid = 1'b0;
  endtask

  // Extra responses push the count past the requests
  task automatic wait_idle();
    while (n_rsp < n_req) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
  endtask

  // Downstream request check and hand-off to the responder
  always @(posedge clk) begin : watch_mst_req
    logic [40:0] exp_req;
    if (mst_req_valid_o && mst_req_ready) begin
      if (exp_q.size() == 0) begin
        check_equal(1, 0, "downstream request with none expected");
      end else begin
        exp_req = exp_q.pop_front();
        check_equal(mst_req_addr_o, exp_req[40:5], "downstream address");
        check_equal(mst_req_id_o, exp_req[4:1], "downstream ID");
        check_equal(mst_req_write_o, exp_req[0], "downstream write flag");
        dn_q.push_back(mst_req_id_o);
      end
    end
    if (mst_rsp_valid && mst_rsp_ready_o) begin
      dn_taken = 1'b1;
    end
  end

  // Upstream responses against the scoreboard, duplicates show as not in flight
  always @(posedge clk) begin : watch_slv_rsp
    if (slv_rsp_valid_o && slv_rsp_ready) begin
      check_equal(pending[slv_rsp_id_o], 1'b1, "response for an ID not in flight");
      check_equal(slv_rsp_resp_o, exp_resp[slv_rsp_id_o], "response code");
      pending[slv_rsp_id_o] = 1'b0;
      n_rsp++;
    end
  end

  // Ready inputs and the downstream responder
  always @(negedge clk) begin : drive_ports
    if (rand_ready) begin
      mst_req_ready = ($random(seed) & 3) != 0;
      slv_rsp_ready = ($random(seed) & 3) != 0;
    end else begin
      mst_req_ready = 1'b1;
      slv_rsp_ready = 1'b1;
    end
    if (dn_taken) begin
      mst_rsp_valid = 1'b0;
      dn_taken      = 1'b0;
    end
    if (!mst_rsp_valid && dn_q.size() > 0) begin
      if (dn_wait == 0) begin
        mst_rsp_valid = 1'b1;
        mst_rsp_id    = dn_q.pop_front();
        dn_wait       = $unsigned($random(seed)) % 6;
      end else begin
        dn_wait--;
      end
    end
  end

  initial begin : main
    rst_n         = 1'b0;
    cfg_we        = 1'b0;
    cfg_addr      = '0;
    cfg_wdata     = '0;
    slv_req_valid = 1'b0;
    slv_req_addr  = '0;
    slv_req_id    = '0;
    slv_req_write = 1'b0;
    mst_req_ready = 1'b1;
    mst_rsp_valid = 1'b0;
    mst_rsp_id    = '0;
    slv_rsp_ready = 1'b1;
    pending       = '0;
    dn_taken      = 1'b0;
    dn_wait       = 0;
    rand_ready    = 1'b0;
    n_req         = 0;
    n_rsp         = 0;
    n_checks      = 0;
    n_errors      = 0;
    for (int e = 0; e < NumEntries; e++) begin
      m_first[e] = '0;
      m_last[e]  = '0;
      m_base[e]  = '0;
      m_valid[e] = 1'b0;
    end
    repeat (16) @(posedge clk);
    check_equal({slv_req_ready_o, mst_req_valid_o, slv_rsp_valid_o}, 0,
                "handshake output high in reset");
    @(negedge clk);
    rst_n = 1'b1;

    // Empty table, every request misses
    for (int i = 0; i < ReqsPerPhase; i++) begin
      send_req($random(seed), 1'($random(seed)));
    end
    wait_idle();

    // Disjoint ranges
    config_ranges(1'b0);
    for (int i = 0; i < ReqsPerPhase; i++) begin
      send_req(addr_near($unsigned($random(seed)) % NumEntries), 1'($random(seed)));
    end
    wait_idle();

    // Overlapping ranges, priority decides
    config_ranges(1'b1);
    for (int i = 0; i < ReqsPerPhase; i++) begin
      send_req({20'h0f0 + 20'($unsigned($random(seed)) % 'h110), 12'($random(seed))},
               1'($random(seed)));
    end
    wait_idle();

    // Back-pressure on both response and request ports
    rand_ready = 1'b1;
    config_ranges(1'b0);
    for (int i = 0; i < ReqsPerPhase; i++) begin
      send_req(addr_near($unsigned($random(seed)) % NumEntries), 1'($random(seed)));
    end
    wait_idle();

    // Entry 1 switched off, a quarter of the traffic aims at it
    cfg_write(1, 2'd3, 32'd0);
    for (int i = 0; i < ReqsPerPhase; i++) begin
      send_req(addr_near(i % NumEntries), 1'($random(seed)));
    end
    wait_idle();

    check_equal(n_rsp, n_req, "responses against accepted requests");
    check_equal(exp_q.size(), 0, "downstream requests never seen");
    $display("Checks: %0d, errors: %0d, requests: %0d", n_checks, n_errors, n_req);
    if (n_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
common/xlate_pkg.sv
common/tlb_lookup_if.sv
tlb/tlb_l1.sv
src/xlate_front.sv
src/err_responder.sv
src/rsp_merge.sv
src/xlate_top.sv
test/tb_xlate_top.sv

//--- Bender.yml
package:
  name: xlate

sources:
  # Package and interface first
  - common/xlate_pkg.sv
  - common/tlb_lookup_if.sv
  # Design
  - tlb/tlb_l1.sv
  - src/xlate_front.sv
  - src/err_responder.sv
  - src/rsp_merge.sv
  - src/xlate_top.sv
  # Testbench
  - target: test
    files:
      - test/tb_xlate_top.sv
